/* tb.f */
+incdir+include
source/objram_pkg.sv
source/objram_dpram.sv
source/objram_axil.sv
source/objram_banks.sv
source/obj_scan.sv
source/objram_top.sv
test/objram_tb.sv

/* test/objram_tb.sv */
`timescale 1ns/1ns

`include "objram_consts.svh"

module objram_tb
    import objram_pkg::*;
();

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [`OBJ_ADDR_W-1:0] ADDR_BANK   = 13'h1000 | `OBJ_REG_BANK;
    localparam logic [`OBJ_ADDR_W-1:0] ADDR_STATUS = 13'h1000 | `OBJ_REG_STATUS;
    // Longest test is 512 table writes at 3 cycles each plus a full scan
    // under back-pressure which comes to about 2000 to 2600 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk_cpu = 1'b0;
    logic       rst_n;
    axil_m2s_t  bus_in;
    axil_s2m_t  bus_out;
    logic       frame_start;
    obj_entry_t obj;
    logic       obj_valid;
    logic       obj_ready = 1'b1;

    // Reference model of both banks plus the bank bit
    obj_entry_t model [0:1][0:255];
    logic       m_bank;

    // Expected responses set before each transaction
    logic [1:0]  exp_bresp = RESP_OKAY;
    logic [1:0]  exp_rresp = RESP_OKAY;
    logic [31:0] exp_rdata = 32'd0;

    // Scan bookkeeping
    int         rec_total = 0;
    int         scan_base = 0;
    int         scan_idx;
    int         exp_cnt = 0;
    logic       scan_active = 1'b0;
    logic       ready_rand = 1'b0;
    obj_entry_t exp_obj;

    // Run control and counts
    int          cycles = 0;
    int          test_start_cycle = 0;
    int          err_count = 0;
    int          test_errs_base = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name = "reset";
    logic [15:0] lfsr_state;

    objram_top uut (
        .clk_cpu     ( clk_cpu     ),
        .rst_n       ( rst_n       ),
        .bus_in      ( bus_in      ),
        .bus_out     ( bus_out     ),
        .frame_start ( frame_start ),
        .obj         ( obj         ),
        .obj_valid   ( obj_valid   ),
        .obj_ready   ( obj_ready   )
    );

    // 8 ns period
    always #4 clk_cpu = ~clk_cpu;

    // Cycle count and per-test time limit
    always @(posedge clk_cpu) begin
        cycles <= cycles + 1;
        if (cycles - test_start_cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: test %s ran past %0d cycles", test_name, TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Every accepted record advances the expected index
    always @(posedge clk_cpu) begin
        if (rst_n && obj_valid && obj_ready) begin
            rec_total <= rec_total + 1;
        end
    end

    assign scan_idx = rec_total - scan_base;
    // Scanner always shows the bank opposite the register
    assign exp_obj  = model[~m_bank][scan_idx[7:0]];

    // Ready is held high or takes one LFSR bit per cycle
    always @(negedge clk_cpu) begin : drive_ready
        logic [31:0] r;
        if (ready_rand) begin
            r = rand_bits(1);
            obj_ready = r[0];
        end else begin
            obj_ready = 1'b1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // x^16 + x^14 + x^13 + x^11 + 1
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic obj_entry_t random_entry(input logic last);
        obj_entry_t  e;
        logic [31:0] r;
        r = rand_bits(32);
        e.x = r[15:0];
        e.y = r[31:16];
        r = rand_bits(32);
        e.code = r[15:0];
        e.attr = r[31:16];
        e.attr[`OBJ_END_BIT] = last;
        return e;
    endfunction

    function automatic logic [`OBJ_ADDR_W-1:0] tbl_addr(input logic win,
                                                        input logic [7:0] idx,
                                                        input logic half);
        // Control bit clear, window, index, word select, byte offset
        return {1'b0, win, idx, half, 2'b00};
    endfunction

    // Records up to the first end flag in the shown bank
    function automatic int expected_count();
        for (int i = 0; i < 256; i++) begin
            if (model[~m_bank][i].attr[`OBJ_END_BIT]) begin
                return i;
            end
        end
        return 256;
    endfunction

    task automatic log_mismatch(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        err_count++;
        $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic log_failure(input string msg);
        err_count++;
        $display("Test %s: %s", test_name, msg);
    endtask

    // No handshake output or scanner state before reset releases
    reset_quiet: assert property (@(negedge clk_cpu) !rst_n && cycles > 0 |->
        !(bus_out.awready || bus_out.wready || bus_out.bvalid || bus_out.arready ||
          bus_out.rvalid || obj_valid || uut.busy || uut.obank))
        else log_failure("an output was active while reset was held");

    // Address and data phases are accepted in the same cycle
    aw_w_paired: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bus_out.awready == bus_out.wready)
        else log_failure("awready and wready were not raised together");

    // Write ready lasts a single cycle
    aw_one_cycle: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bus_out.awready |=> !bus_out.awready)
        else log_failure("awready stayed high for more than one cycle");

    // Stalled record holds
    obj_hold: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid && !obj_ready |=> obj_valid && $stable(obj))
        else log_failure("record changed or dropped while stalled");

    // Records only while a scan is running
    obj_in_scan: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !scan_active |-> !obj_valid)
        else log_failure("record emitted outside a scan");

    obj_in_range: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid && obj_ready |-> scan_idx < exp_cnt)
        else log_failure("record emitted past the end of the table");

    obj_match: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid && obj_ready |-> obj == exp_obj)
        else log_mismatch("record", $sampled(exp_obj), $sampled(obj));

    bresp_match: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bus_out.bvalid && bus_in.bready |-> bus_out.bresp == exp_bresp)
        else log_mismatch("bresp", 64'($sampled(exp_bresp)), 64'($sampled(bus_out.bresp)));

    rresp_match: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bus_out.rvalid && bus_in.rready |->
        {bus_out.rresp, bus_out.rdata} == {exp_rresp, exp_rdata})
        else log_mismatch("read", 64'($sampled({exp_rresp, exp_rdata})),
                          64'($sampled({bus_out.rresp, bus_out.rdata})));

    // Apply one bus write to the model
    task automatic model_write(input logic [`OBJ_ADDR_W-1:0] addr,
                               input logic [31:0] data, input logic [3:0] strb);
        logic        b;
        logic [7:0]  i;
        logic [31:0] word;
        if (!addr[`OBJ_CTRL_BIT]) begin
            b = m_bank ^ addr[`OBJ_WIN_BIT];
            i = addr[`OBJ_IDX_W+2:3];
            if (!addr[2]) begin
                word = {model[b][i].y, model[b][i].x};
            end else begin
                word = {model[b][i].attr, model[b][i].code};
            end
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) begin
                    word[k*8 +: 8] = data[k*8 +: 8];
                end
            end
            if (!addr[2]) begin
                model[b][i].x = word[15:0];
                model[b][i].y = word[31:16];
            end else begin
                model[b][i].code = word[15:0];
                model[b][i].attr = word[31:16];
            end
        end else if (addr[`OBJ_CTRL_BIT-1:0] == `OBJ_REG_BANK && strb[0]) begin
            m_bank = data[0];
        end
    endtask

    // Called and returns on a falling edge
    task automatic axil_write(input logic [`OBJ_ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
        // Only the status register refuses writes
        if (addr == ADDR_STATUS) begin
            exp_bresp = RESP_SLVERR;
        end else begin
            exp_bresp = RESP_OKAY;
        end
        bus_in.awaddr  = addr;
        bus_in.wdata   = data;
        bus_in.wstrb   = strb;
        bus_in.awvalid = 1'b1;
        bus_in.wvalid  = 1'b1;
        bus_in.bready  = 1'b1;
        @(negedge clk_cpu);
        while (!bus_out.awready) @(negedge clk_cpu);
        // Handshake on the edge in between
        @(negedge clk_cpu);
        bus_in.awvalid = 1'b0;
        bus_in.wvalid  = 1'b0;
        while (!bus_out.bvalid) @(negedge clk_cpu);
        @(negedge clk_cpu);
        bus_in.bready = 1'b0;
        model_write(addr, data, strb);
    endtask

    task automatic axil_read(input logic [`OBJ_ADDR_W-1:0] addr,
                             input logic [31:0] exp_d, input logic [1:0] exp_r);
        exp_rdata      = exp_d;
        exp_rresp      = exp_r;
        bus_in.araddr  = addr;
        bus_in.arvalid = 1'b1;
        bus_in.rready  = 1'b1;
        @(negedge clk_cpu);
        while (!bus_out.arready) @(negedge clk_cpu);
        @(negedge clk_cpu);
        bus_in.arvalid = 1'b0;
        while (!bus_out.rvalid) @(negedge clk_cpu);
        @(negedge clk_cpu);
        bus_in.rready = 1'b0;
    endtask

    task automatic write_entry(input logic win, input logic [7:0] idx, input obj_entry_t e);
        axil_write(tbl_addr(win, idx, 1'b0), {e.y, e.x}, 4'hF);
        axil_write(tbl_addr(win, idx, 1'b1), {e.attr, e.code}, 4'hF);
    endtask

    task automatic pulse_frame();
        frame_start = 1'b1;
        @(negedge clk_cpu);
        frame_start = 1'b0;
    endtask

    task automatic scan_begin(input logic rnd);
        exp_cnt     = expected_count();
        scan_base   = rec_total;
        ready_rand  = rnd;
        scan_active = 1'b1;
        pulse_frame();
    endtask

    // Wait for busy to drop and the last record to drain
    task automatic scan_finish();
        while (uut.busy || obj_valid) @(negedge clk_cpu);
        scan_active = 1'b0;
        ready_rand  = 1'b0;
        scan_count: assert (scan_idx == exp_cnt)
            else log_mismatch("record count", 64'(exp_cnt), 64'(scan_idx));
    endtask

    task automatic run_scan(input logic rnd);
        scan_begin(rnd);
        scan_finish();
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        test_errs_base   = err_count;
        test_start_cycle = cycles;
    endtask

    task automatic end_test();
        if (err_count == test_errs_base) begin
            tests_passed++;
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, err_count - test_errs_base);
        end
    endtask

    initial begin
        bus_in      = '0;
        frame_start = 1'b0;
        rst_n       = 1'b0;
        lfsr_state  = 16'd48;
        m_bank      = 1'b0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 256; i++) begin
                model[b][i] = '0;
            end
        end
        repeat (10) @(negedge clk_cpu);
        rst_n = 1'b1;
        @(negedge clk_cpu);

        start_test("reset_state");
        axil_read(ADDR_BANK, 32'd0, RESP_OKAY);
        axil_read(ADDR_STATUS, 32'd0, RESP_OKAY);
        end_test();

        // 20 entries and an end entry into the hidden bank before the flip
        start_test("basic_scan");
        for (int i = 0; i < 20; i++) begin
            write_entry(1'b0, 8'(i), random_entry(1'b0));
        end
        write_entry(1'b0, 8'd20, random_entry(1'b1));
        axil_write(ADDR_BANK, 32'd1, 4'b0001);
        run_scan(1'b0);
        end_test();

        start_test("partial_strobe");
        axil_write(tbl_addr(1'b1, 8'd3, 1'b0), rand_bits(32), 4'b0101);
        // Lanes 1 and 2 only so the end flag byte stays put
        axil_write(tbl_addr(1'b1, 8'd7, 1'b1), rand_bits(32), 4'b0110);
        run_scan(1'b0);
        end_test();

        start_test("window_flip");
        write_entry(1'b1, 8'd5, random_entry(1'b0));
        run_scan(1'b0);
        // Fresh hidden table stays invisible until flipped back
        for (int i = 0; i < 6; i++) begin
            write_entry(1'b0, 8'(i), random_entry(1'b0));
        end
        write_entry(1'b0, 8'd6, random_entry(1'b1));
        run_scan(1'b0);
        axil_write(ADDR_BANK, 32'd0, 4'b0001);
        run_scan(1'b0);
        end_test();

        start_test("backpressure");
        run_scan(1'b1);
        // Full table with no end flag
        for (int i = 0; i < 256; i++) begin
            write_entry(1'b0, 8'(i), random_entry(1'b0));
        end
        axil_write(ADDR_BANK, 32'd1, 4'b0001);
        run_scan(1'b1);
        end_test();

        start_test("error_resp");
        axil_read(tbl_addr(1'b0, 8'd0, 1'b0), 32'd0, RESP_SLVERR);
        axil_read(tbl_addr(1'b1, 8'd9, 1'b1), 32'd0, RESP_SLVERR);
        axil_write(ADDR_STATUS, 32'd1, 4'hF);
        axil_read(ADDR_BANK, {31'd0, m_bank}, RESP_OKAY);
        scan_begin(1'b1);
        axil_read(ADDR_STATUS, 32'd1, RESP_OKAY);
        // Restart request mid-scan must be ignored
        pulse_frame();
        scan_finish();
        end_test();

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* source/objram_top.sv */
`timescale 1ns/1ns

`include "objram_consts.svh"

module objram_top
    import objram_pkg::*;
(
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  axil_m2s_t  bus_in,
    output axil_s2m_t  bus_out,
    input  logic       frame_start,
    output obj_entry_t obj,
    output logic       obj_valid,
    input  logic       obj_ready
);

    // CPU side to table
    tbl_wr_t tbl_wr;
    logic    tbl_we;
    logic    obank;

    // Scanner side
    logic [`OBJ_IDX_W-1:0] rd_index;
    obj_entry_t            rd_entry;
    logic                  busy;

    // Bus slave, bank and status registers
    objram_axil u_axil (
        .clk_cpu ( clk_cpu ),
        .rst_n   ( rst_n   ),
        .bus_in  ( bus_in  ),
        .bus_out ( bus_out ),
        .tbl_wr  ( tbl_wr  ),
        .tbl_we  ( tbl_we  ),
        .obank   ( obank   ),
        .busy    ( busy    )
    );

    // Double-buffered table
    objram_banks u_banks (
        .clk_cpu  ( clk_cpu  ),
        .tbl_wr   ( tbl_wr   ),
        .tbl_we   ( tbl_we   ),
        .obank    ( obank    ),
        .rd_index ( rd_index ),
        .rd_entry ( rd_entry )
    );

    // Frame walker
    obj_scan u_scan (
        .clk_cpu     ( clk_cpu     ),
        .rst_n       ( rst_n       ),
        .frame_start ( frame_start ),
        .rd_index    ( rd_index    ),
        .rd_entry    ( rd_entry    ),
        .obj         ( obj         ),
        .obj_valid   ( obj_valid   ),
        .obj_ready   ( obj_ready   ),
        .busy        ( busy        )
    );

endmodule

/* source/obj_scan.sv */
`timescale 1ns/1ns

`include "objram_consts.svh"

module obj_scan
    import objram_pkg::*;
(
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  frame_start,
    output logic [`OBJ_IDX_W-1:0] rd_index,
    input  obj_entry_t            rd_entry,
    output obj_entry_t            obj,
    output logic                  obj_valid,
    input  logic                  obj_ready,
    output logic                  busy
);

    // Read issued last cycle, rd_entry valid now
    logic pend;
    // Last index already sent to the RAM
    logic all_issued;
    logic issue;
    logic hit_end;
    logic load;

    // Only read when the output slot is sure to be empty on return
    // No read in flight and output empty or draining this cycle
    assign issue = busy && !all_issued && !pend && (!obj_valid || obj_ready);

    // End flag seen on the returning entry
    assign hit_end = pend && rd_entry.attr[`OBJ_END_BIT];

    // Returning entry goes to the output unless it ends the list
    assign load = pend && !hit_end;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            pend       <= 1'b0;
            all_issued <= 1'b0;
            rd_index   <= '0;
        end else begin
            pend <= issue;
            if (!busy) begin
                // New frame, walk from entry 0
                if (frame_start) begin
                    busy       <= 1'b1;
                    rd_index   <= '0;
                    all_issued <= 1'b0;
                end
            end else begin
                if (issue) begin
                    rd_index <= rd_index + 1'b1;
                    if (rd_index == '1) begin
                        all_issued <= 1'b1;
                    end
                end
                // Done at the end flag or once entry 255 is back
                if (hit_end || (pend && all_issued)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Output valid, held until taken
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            obj_valid <= 1'b0;
        end else if (load) begin
            obj_valid <= 1'b1;
        end else if (obj_ready) begin
            obj_valid <= 1'b0;
        end
    end

    // Output record, only loaded into an empty slot
    always_ff @(posedge clk_cpu) begin
        if (load) begin
            obj <= rd_entry;
        end
    end

endmodule

/* source/objram_banks.sv */
`timescale 1ns/1ns

`include "objram_consts.svh"

module objram_banks
    import objram_pkg::*;
(
    input  logic                  clk_cpu,
    input  tbl_wr_t               tbl_wr,
    input  logic                  tbl_we,
    input  logic                  obank,
    input  logic [`OBJ_IDX_W-1:0] rd_index,
    output obj_entry_t            rd_entry
);

    // Bank bit on top, entry index below
    logic [`OBJ_IDX_W:0] wr_addr;
    logic [`OBJ_IDX_W:0] rd_addr;
    logic [3:0]          xy_strobe;
    logic [3:0]          ca_strobe;
    logic [31:0]         xy_q;
    logic [31:0]         ca_q;

    // Window 0 lands in the hidden bank, window 1 in the shown one
    assign wr_addr = {obank ^ tbl_wr.window, tbl_wr.index};

    // Scanner always reads the displayed bank
    assign rd_addr = {~obank, rd_index};

    // Steer strobes by half
    assign xy_strobe = (tbl_we && !tbl_wr.half) ? tbl_wr.strobe : 4'd0;
    assign ca_strobe = (tbl_we &&  tbl_wr.half) ? tbl_wr.strobe : 4'd0;

    // X low, Y high
    objram_dpram #(.DW(32), .AW(`OBJ_IDX_W+1)) u_xy (
        .clk_cpu   ( clk_cpu     ),
        .wr_addr   ( wr_addr     ),
        .wr_data   ( tbl_wr.data ),
        .wr_strobe ( xy_strobe   ),
        .rd_addr   ( rd_addr     ),
        .rd_data   ( xy_q        )
    );

    // Code low, attr high
    objram_dpram #(.DW(32), .AW(`OBJ_IDX_W+1)) u_ca (
        .clk_cpu   ( clk_cpu     ),
        .wr_addr   ( wr_addr     ),
        .wr_data   ( tbl_wr.data ),
        .wr_strobe ( ca_strobe   ),
        .rd_addr   ( rd_addr     ),
        .rd_data   ( ca_q        )
    );

    // Both halves come back in the same cycle
    assign rd_entry.x    = xy_q[15:0];
    assign rd_entry.y    = xy_q[31:16];
    assign rd_entry.code = ca_q[15:0];
    assign rd_entry.attr = ca_q[31:16];

endmodule

/* source/objram_axil.sv */
`timescale 1ns/1ns

`include "objram_consts.svh"

module objram_axil
    import objram_pkg::*;
(
    input  logic      clk_cpu,
    input  logic      rst_n,
    input  axil_m2s_t bus_in,
    output axil_s2m_t bus_out,
    output tbl_wr_t   tbl_wr,
    output logic      tbl_we,
    output logic      obank,
    input  logic      busy
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Handshake and response state
    logic        wr_rdy;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rd_rdy;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // Address decode
    logic                    wr_hs;
    logic                    rd_hs;
    logic                    aw_ctrl;
    logic                    ar_ctrl;
    logic [`OBJ_CTRL_BIT-1:0] aw_off;
    logic [`OBJ_CTRL_BIT-1:0] ar_off;

    assign wr_hs   = wr_rdy && bus_in.awvalid && bus_in.wvalid;
    assign rd_hs   = rd_rdy && bus_in.arvalid;
    assign aw_ctrl = bus_in.awaddr[`OBJ_CTRL_BIT];
    assign ar_ctrl = bus_in.araddr[`OBJ_CTRL_BIT];
    assign aw_off  = bus_in.awaddr[`OBJ_CTRL_BIT-1:0];
    assign ar_off  = bus_in.araddr[`OBJ_CTRL_BIT-1:0];

    // Write channel
    // AW and W accepted together, one transaction at a time
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
            tbl_we <= 1'b0;
            obank  <= 1'b0;
        end else begin
            wr_rdy <= !wr_rdy && !bvalid && bus_in.awvalid && bus_in.wvalid;
            tbl_we <= wr_hs && !aw_ctrl;
            if (wr_hs) begin
                bvalid <= 1'b1;
                // Bank bit lives in byte lane 0
                if (aw_ctrl && aw_off == `OBJ_REG_BANK && bus_in.wstrb[0]) begin
                    obank <= bus_in.wdata[0];
                end
            end else if (bvalid && bus_in.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Write payload and response code
    always_ff @(posedge clk_cpu) begin
        if (wr_hs) begin
            tbl_wr.window <= bus_in.awaddr[`OBJ_WIN_BIT];
            // Address bit 2 picks XY or code/attr
            tbl_wr.half   <= bus_in.awaddr[2];
            tbl_wr.index  <= bus_in.awaddr[`OBJ_IDX_W+2:3];
            tbl_wr.data   <= bus_in.wdata;
            tbl_wr.strobe <= bus_in.wstrb;
            // Status is read only, other control offsets unmapped
            if (aw_ctrl && aw_off != `OBJ_REG_BANK) begin
                bresp <= RESP_SLVERR;
            end else begin
                bresp <= RESP_OKAY;
            end
        end
    end

    // Read channel
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rd_rdy <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            rd_rdy <= !rd_rdy && !rvalid && bus_in.arvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && bus_in.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data, table is write only
    always_ff @(posedge clk_cpu) begin
        if (rd_hs) begin
            if (ar_ctrl && ar_off == `OBJ_REG_BANK) begin
                rdata <= {31'd0, obank};
                rresp <= RESP_OKAY;
            end else if (ar_ctrl && ar_off == `OBJ_REG_STATUS) begin
                rdata <= {31'd0, busy};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= 32'd0;
                rresp <= RESP_SLVERR;
            end
        end
    end

    assign bus_out.awready = wr_rdy;
    assign bus_out.wready  = wr_rdy;
    assign bus_out.bvalid  = bvalid;
    assign bus_out.bresp   = bresp;
    assign bus_out.arready = rd_rdy;
    assign bus_out.rvalid  = rvalid;
    assign bus_out.rdata   = rdata;
    assign bus_out.rresp   = rresp;

endmodule

/* source/objram_dpram.sv */
`timescale 1ns/1ns

module objram_dpram #(
    parameter int DW = 32,
    parameter int AW = 9
) (
    input  logic            clk_cpu,
    input  logic [AW-1:0]   wr_addr,
    input  logic [DW-1:0]   wr_data,
    input  logic [DW/8-1:0] wr_strobe,
    input  logic [AW-1:0]   rd_addr,
    output logic [DW-1:0]   rd_data
);

    // Storage, one word per address
    logic [DW-1:0] mem [0:(1<<AW)-1];

    // Byte lanes written only where strobed
    // An all-zero strobe is simply no write
    always_ff @(posedge clk_cpu) begin
        for (int b = 0; b < DW/8; b++) begin
            if (wr_strobe[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

    // Registered read, one cycle latency
    // Same-address collision returns the old word
    always_ff @(posedge clk_cpu) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/objram_pkg.sv */
`include "objram_consts.svh"

package objram_pkg;

    // Manager to subordinate, AXI4-Lite
    typedef struct packed {
        logic                   awvalid;
        logic [`OBJ_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [`OBJ_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_m2s_t;

    // Subordinate to manager, AXI4-Lite
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_s2m_t;

    // One CPU write into the object table
    typedef struct packed {
        // Window bit from the address, not yet mapped to a bank
        logic                  window;
        // 0 is the XY word, 1 the code/attr word
        logic                  half;
        logic [`OBJ_IDX_W-1:0] index;
        logic [31:0]           data;
        logic [3:0]            strobe;
    } tbl_wr_t;

    // Full object entry as the scanner sees it
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
    } obj_entry_t;

endpackage

/* include/objram_consts.svh */
`ifndef OBJRAM_CONSTS_SVH
`define OBJRAM_CONSTS_SVH

// Entry index width, 256 entries per bank
`define OBJ_IDX_W 8

// AXI byte address width
`define OBJ_ADDR_W 13

// Byte address bit picking the CPU window
// 0 maps to the hidden bank, 1 to the displayed bank
`define OBJ_WIN_BIT 11

// Byte address bit selecting control space over the table
`define OBJ_CTRL_BIT 12

// Control register offsets
`define OBJ_REG_BANK 0
`define OBJ_REG_STATUS 4

// End-of-list flag in the attr word
`define OBJ_END_BIT 15

`endif
